// ==== common/aib_pkg.sv ====
package aib_pkg;

   // --------------------------------------------------
   // Link widths
   // --------------------------------------------------

   // One half word on the die-to-die link
   localparam int AIB_HALF_W = 40;

   // Marker on top, valid just below
   localparam int AIB_MARK_BIT  = AIB_HALF_W - 1;
   localparam int AIB_VALID_BIT = AIB_HALF_W - 2;

   // Payload left in a half word
   localparam int AIB_PAYLOAD_W = AIB_HALF_W - 2;

   // Two payload halves per user word
   localparam int AIB_WORD_W = 2 * AIB_PAYLOAD_W;

   typedef logic [AIB_HALF_W-1:0]    aib_half_t;
   typedef logic [AIB_PAYLOAD_W-1:0] aib_payload_t;
   typedef logic [AIB_WORD_W-1:0]    aib_word_t;

   // --------------------------------------------------
   // Register bus
   // --------------------------------------------------

   typedef logic [1:0]  aib_reg_addr_t;
   typedef logic [31:0] aib_reg_data_t;

   // Register map
   localparam aib_reg_addr_t AIB_REG_CTRL   = 2'd0;
   localparam aib_reg_addr_t AIB_REG_STATUS = 2'd1;
   localparam aib_reg_addr_t AIB_REG_LOSS   = 2'd2;
   localparam aib_reg_addr_t AIB_REG_RXCNT  = 2'd3;

   // Avalon-MM style request, one-cycle strobes
   typedef struct packed {
      logic          write;
      logic          read;
      aib_reg_addr_t address;
      aib_reg_data_t writedata;
   } aib_avmm_req_t;

   // Receive aligner FSM
   typedef enum logic [1:0] {
      align_hunt,
      align_verify,
      align_locked
   } aib_align_state_t;

endpackage

// ==== aib/aib_tx_gearbox.sv ====
module aib_tx_gearbox
(
   input  logic               fwd_clk,
   input  logic               reset,
   input  logic               tx_en,
   input  logic               tx_valid,
   input  aib_pkg::aib_word_t tx_data,
   output aib_pkg::aib_half_t tx_half
);

   // Local shorthands for the half word layout
   localparam int MARK = aib_pkg::AIB_MARK_BIT;
   localparam int VLD  = aib_pkg::AIB_VALID_BIT;
   localparam int PW   = aib_pkg::AIB_PAYLOAD_W;
   localparam int WW   = aib_pkg::AIB_WORD_W;

   // Phase 0 on the first cycle out of reset
   logic phase;

   // Sampled word, both halves kept until sent
   aib_pkg::aib_word_t word_q;
   logic               word_vld;

   // Next half word on the link
   aib_pkg::aib_half_t half_nxt;

   // --------------------------------------------------
   // Phase and word capture
   // --------------------------------------------------

   always_ff @(posedge fwd_clk)
   begin
      if (reset)
         phase <= 1'b0;
      else
         phase <= ~phase;
   end

   // Valid only updates on phase 0, cleared while disabled
   always_ff @(posedge fwd_clk)
   begin
      if (reset)
         word_vld <= 1'b0;
      else if (!tx_en)
         word_vld <= 1'b0;
      else if (!phase)
         word_vld <= tx_valid;
   end

   // Payload, old high half still read on this same edge
   always_ff @(posedge fwd_clk)
   begin
      if (!phase && tx_en && tx_valid)
         word_q <= tx_data;
   end

   // --------------------------------------------------
   // Half word select
   // --------------------------------------------------

   always_comb
   begin
      half_nxt = '0;
      // Disabled link sends zeros, markers stop alternating
      if (tx_en)
      begin
         // Phase 1 edge sends the low half with marker set
         half_nxt[MARK] = phase;
         half_nxt[VLD]  = word_vld;
         if (word_vld)
            half_nxt[PW-1:0] = phase ? word_q[PW-1:0] : word_q[WW-1:PW];
      end
   end

   always_ff @(posedge fwd_clk)
   begin
      if (reset)
         tx_half <= '0;
      else
         tx_half <= half_nxt;
   end

endmodule

// ==== aib/aib_rx_aligner.sv ====
module aib_rx_aligner
#(
   parameter int LOCK_COUNT = 4
)
(
   input  logic               fwd_clk,
   input  logic               reset,
   input  logic               rx_en,
   input  aib_pkg::aib_half_t rx_half,
   output logic               lock,
   output logic               lock_loss,
   output logic               rx_valid,
   output aib_pkg::aib_word_t rx_data
);

   localparam int MARK  = aib_pkg::AIB_MARK_BIT;
   localparam int VLD   = aib_pkg::AIB_VALID_BIT;
   localparam int PW    = aib_pkg::AIB_PAYLOAD_W;
   // Wide enough to hold LOCK_COUNT
   localparam int CNT_W = $clog2(LOCK_COUNT + 1);

   // Input register
   aib_pkg::aib_half_t rx_q;

   // Marker seen one cycle earlier
   logic last_mark;
   logic mark_ok;

   aib_pkg::aib_align_state_t state;
   logic [CNT_W-1:0]          verify_cnt;

   // First half waiting for its partner
   aib_pkg::aib_payload_t first_q;
   logic                  first_vld;

   logic deliver;

   always_ff @(posedge fwd_clk)
   begin
      if (reset)
      begin
         rx_q      <= '0;
         last_mark <= 1'b0;
      end
      else
      begin
         rx_q      <= rx_half;
         last_mark <= rx_q[MARK];
      end
   end

   // Correct when marker flips from the last half
   assign mark_ok = rx_q[MARK] ^ last_mark;

   // --------------------------------------------------
   // Marker lock FSM
   // --------------------------------------------------

   always_ff @(posedge fwd_clk)
   begin
      if (reset)
      begin
         state      <= aib_pkg::align_hunt;
         verify_cnt <= '0;
         lock_loss  <= 1'b0;
      end
      else
      begin
         lock_loss <= 1'b0;
         case (state)
            aib_pkg::align_hunt:
            begin
               verify_cnt <= '0;
               // A first half starts verification
               if (rx_q[MARK])
                  state <= aib_pkg::align_verify;
            end
            aib_pkg::align_verify:
            begin
               if (!mark_ok)
               begin
                  state      <= aib_pkg::align_hunt;
                  verify_cnt <= '0;
               end
               else if (verify_cnt == CNT_W'(LOCK_COUNT - 1))
                  state <= aib_pkg::align_locked;
               else
                  verify_cnt <= verify_cnt + 1'b1;
            end
            aib_pkg::align_locked:
            begin
               // One wrong marker is enough to drop lock
               if (!mark_ok)
               begin
                  state     <= aib_pkg::align_hunt;
                  lock_loss <= 1'b1;
               end
            end
            default:
               state <= aib_pkg::align_hunt;
         endcase
      end
   end

   assign lock = (state == aib_pkg::align_locked);

   // --------------------------------------------------
   // Word reassembly
   // --------------------------------------------------

   // Valid flag consumed by the next half either way
   always_ff @(posedge fwd_clk)
   begin
      if (reset)
         first_vld <= 1'b0;
      else
         first_vld <= rx_q[MARK] & rx_q[VLD];
   end

   always_ff @(posedge fwd_clk)
   begin
      if (rx_q[MARK])
         first_q <= rx_q[PW-1:0];
   end

   // Second half in place, partner held, delivery allowed
   assign deliver = lock && mark_ok && !rx_q[MARK] && rx_q[VLD] && first_vld && rx_en;

   always_ff @(posedge fwd_clk)
   begin
      if (reset)
         rx_valid <= 1'b0;
      else
         rx_valid <= deliver;
   end

   // High half on top
   always_ff @(posedge fwd_clk)
   begin
      if (deliver)
         rx_data <= {rx_q[PW-1:0], first_q};
   end

endmodule

// ==== aib/aib_csr.sv ====
module aib_csr
(
   input  logic                   fwd_clk,
   input  logic                   reset,
   input  aib_pkg::aib_avmm_req_t avmm_req,
   input  logic                   lock,
   input  logic                   lock_loss,
   input  logic                   rx_valid,
   output aib_pkg::aib_reg_data_t avmm_readdata,
   output logic                   avmm_readdatavalid,
   output logic                   tx_en,
   output logic                   rx_en
);

   // bit0 tx_en, bit1 rx_en
   logic [1:0] ctrl;

   // Saturating event counters
   aib_pkg::aib_reg_data_t loss_cnt;
   aib_pkg::aib_reg_data_t rx_cnt;

   // Write decode
   logic wr_ctrl;
   logic wr_loss;
   logic wr_rxcnt;

   // Read mux output
   aib_pkg::aib_reg_data_t rd_mux;

   assign wr_ctrl  = avmm_req.write && (avmm_req.address == aib_pkg::AIB_REG_CTRL);
   assign wr_loss  = avmm_req.write && (avmm_req.address == aib_pkg::AIB_REG_LOSS);
   assign wr_rxcnt = avmm_req.write && (avmm_req.address == aib_pkg::AIB_REG_RXCNT);

   // --------------------------------------------------
   // Control and counters
   // --------------------------------------------------

   always_ff @(posedge fwd_clk)
   begin
      if (reset)
         ctrl <= '0;
      else if (wr_ctrl)
         ctrl <= avmm_req.writedata[1:0];
   end

   assign tx_en = ctrl[0];
   assign rx_en = ctrl[1];

   // Any write clears, the clear wins over a same-cycle event
   always_ff @(posedge fwd_clk)
   begin
      if (reset)
         loss_cnt <= '0;
      else if (wr_loss)
         loss_cnt <= '0;
      else if (lock_loss && (loss_cnt != '1))
         loss_cnt <= loss_cnt + 1'b1;
   end

   always_ff @(posedge fwd_clk)
   begin
      if (reset)
         rx_cnt <= '0;
      else if (wr_rxcnt)
         rx_cnt <= '0;
      else if (rx_valid && (rx_cnt != '1))
         rx_cnt <= rx_cnt + 1'b1;
   end

   // --------------------------------------------------
   // Readback, one cycle latency
   // --------------------------------------------------

   always_comb
   begin
      case (avmm_req.address)
         aib_pkg::AIB_REG_CTRL:   rd_mux = {30'b0, ctrl};
         aib_pkg::AIB_REG_STATUS: rd_mux = {31'b0, lock};
         aib_pkg::AIB_REG_LOSS:   rd_mux = loss_cnt;
         default:                 rd_mux = rx_cnt;
      endcase
   end

   always_ff @(posedge fwd_clk)
   begin
      if (reset)
         avmm_readdatavalid <= 1'b0;
      else
         avmm_readdatavalid <= avmm_req.read;
   end

   always_ff @(posedge fwd_clk)
   begin
      if (avmm_req.read)
         avmm_readdata <= rd_mux;
   end

endmodule

// ==== aib/aib_model_top.sv ====
module aib_model_top
#(
   parameter int LOCK_COUNT = 4
)
(
   input  logic                   fwd_clk,
   input  logic                   reset,
   // Register bus
   input  aib_pkg::aib_avmm_req_t avmm_req,
   output aib_pkg::aib_reg_data_t avmm_readdata,
   output logic                   avmm_readdatavalid,
   // User transmit side
   input  logic                   tx_valid,
   input  aib_pkg::aib_word_t     tx_data,
   // User receive side
   output logic                   rx_valid,
   output aib_pkg::aib_word_t     rx_data,
   // Die-to-die link
   input  aib_pkg::aib_half_t     rx_half,
   output aib_pkg::aib_half_t     tx_half
);

   // Enables from the control register
   logic tx_en;
   logic rx_en;

   // Aligner status into the register block
   logic lock;
   logic lock_loss;

   // --------------------------------------------------
   // Transmit path
   // --------------------------------------------------

   aib_tx_gearbox i_tx_gearbox
   (
      .fwd_clk  (fwd_clk),
      .reset    (reset),
      .tx_en    (tx_en),
      .tx_valid (tx_valid),
      .tx_data  (tx_data),
      .tx_half  (tx_half)
   );

   // --------------------------------------------------
   // Receive path
   // --------------------------------------------------

   aib_rx_aligner #(.LOCK_COUNT(LOCK_COUNT)) i_rx_aligner
   (
      .fwd_clk   (fwd_clk),
      .reset     (reset),
      .rx_en     (rx_en),
      .rx_half   (rx_half),
      .lock      (lock),
      .lock_loss (lock_loss),
      .rx_valid  (rx_valid),
      .rx_data   (rx_data)
   );

   // Registers, also count delivered words
   aib_csr i_csr
   (
      .fwd_clk            (fwd_clk),
      .reset              (reset),
      .avmm_req           (avmm_req),
      .lock               (lock),
      .lock_loss          (lock_loss),
      .rx_valid           (rx_valid),
      .avmm_readdata      (avmm_readdata),
      .avmm_readdatavalid (avmm_readdatavalid),
      .tx_en              (tx_en),
      .rx_en              (rx_en)
   );

endmodule

// ==== hdl/aib_link_top.sv ====
module aib_link_top
#(
   parameter int LOCK_COUNT = 4
)
(
   input  logic                   fwd_clk,
   input  logic                   reset,
   // Master channel
   input  aib_pkg::aib_avmm_req_t ms1_avmm_req,
   input  logic                   ms1_tx_valid,
   input  aib_pkg::aib_word_t     ms1_tx_data,
   output aib_pkg::aib_reg_data_t ms1_avmm_readdata,
   output logic                   ms1_avmm_readdatavalid,
   output logic                   ms1_rx_valid,
   output aib_pkg::aib_word_t     ms1_rx_data,
   // Slave channel
   input  aib_pkg::aib_avmm_req_t sl1_avmm_req,
   input  logic                   sl1_tx_valid,
   input  aib_pkg::aib_word_t     sl1_tx_data,
   output aib_pkg::aib_reg_data_t sl1_avmm_readdata,
   output logic                   sl1_avmm_readdatavalid,
   output logic                   sl1_rx_valid,
   output aib_pkg::aib_word_t     sl1_rx_data
);

   // Crossed link wires
   aib_pkg::aib_half_t ms1_tx_half;
   aib_pkg::aib_half_t sl1_tx_half;

   // Master, receives the slave's half words
   aib_model_top #(.LOCK_COUNT(LOCK_COUNT)) dut_master1
   (
      .fwd_clk            (fwd_clk),
      .reset              (reset),
      .avmm_req           (ms1_avmm_req),
      .avmm_readdata      (ms1_avmm_readdata),
      .avmm_readdatavalid (ms1_avmm_readdatavalid),
      .tx_valid           (ms1_tx_valid),
      .tx_data            (ms1_tx_data),
      .rx_valid           (ms1_rx_valid),
      .rx_data            (ms1_rx_data),
      .rx_half            (sl1_tx_half),
      .tx_half            (ms1_tx_half)
   );

   // Slave, same model on the other die
   aib_model_top #(.LOCK_COUNT(LOCK_COUNT)) dut_slave1
   (
      .fwd_clk            (fwd_clk),
      .reset              (reset),
      .avmm_req           (sl1_avmm_req),
      .avmm_readdata      (sl1_avmm_readdata),
      .avmm_readdatavalid (sl1_avmm_readdatavalid),
      .tx_valid           (sl1_tx_valid),
      .tx_data            (sl1_tx_data),
      .rx_valid           (sl1_rx_valid),
      .rx_data            (sl1_rx_data),
      .rx_half            (ms1_tx_half),
      .tx_half            (sl1_tx_half)
   );

endmodule

// ==== sim/top_tb.sv ====
module top_tb;

   localparam int CLK_PERIOD = 20;
   localparam int LATENCY    = 4;
   localparam int NUM_STIM   = 12;
   localparam int WAIT_LIMIT = 40;

   // Table row where dir 0 means the master sends
   typedef struct packed {
      logic               dir;
      logic               ph;
      aib_pkg::aib_word_t word;
   } stim_t;

   logic                   fwd_clk;
   logic                   reset;
   aib_pkg::aib_avmm_req_t ms1_avmm_req;
   logic                   ms1_tx_valid;
   aib_pkg::aib_word_t     ms1_tx_data;
   aib_pkg::aib_reg_data_t ms1_avmm_readdata;
   logic                   ms1_avmm_readdatavalid;
   logic                   ms1_rx_valid;
   aib_pkg::aib_word_t     ms1_rx_data;
   aib_pkg::aib_avmm_req_t sl1_avmm_req;
   logic                   sl1_tx_valid;
   aib_pkg::aib_word_t     sl1_tx_data;
   aib_pkg::aib_reg_data_t sl1_avmm_readdata;
   logic                   sl1_avmm_readdatavalid;
   logic                   sl1_rx_valid;
   aib_pkg::aib_word_t     sl1_rx_data;

   stim_t  stim [NUM_STIM];
   integer seed;
   int     errors;
   int     checks;
   // Edges since reset release
   // Bit 0 matches the gearbox phase
   int     cyc;
   logic [1:0] ctrl_mirror [2];
   int     exp_rxcnt [2];

   // Expected words and arrival times per receiving side
   aib_pkg::aib_word_t ms_exp_word [$];
   aib_pkg::aib_word_t sl_exp_word [$];
   time                ms_exp_time [$];
   time                sl_exp_time [$];

   aib_link_top #(.LOCK_COUNT(4)) i_aib_link_top
   (
      .fwd_clk                (fwd_clk),
      .reset                  (reset),
      .ms1_avmm_req           (ms1_avmm_req),
      .ms1_tx_valid           (ms1_tx_valid),
      .ms1_tx_data            (ms1_tx_data),
      .ms1_avmm_readdata      (ms1_avmm_readdata),
      .ms1_avmm_readdatavalid (ms1_avmm_readdatavalid),
      .ms1_rx_valid           (ms1_rx_valid),
      .ms1_rx_data            (ms1_rx_data),
      .sl1_avmm_req           (sl1_avmm_req),
      .sl1_tx_valid           (sl1_tx_valid),
      .sl1_tx_data            (sl1_tx_data),
      .sl1_avmm_readdata      (sl1_avmm_readdata),
      .sl1_avmm_readdatavalid (sl1_avmm_readdatavalid),
      .sl1_rx_valid           (sl1_rx_valid),
      .sl1_rx_data            (sl1_rx_data)
   );

   initial
   begin
      fwd_clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) fwd_clk = ~fwd_clk;
   end

   always @(posedge fwd_clk)
   begin
      if (reset)
         cyc <= 0;
      else
         cyc <= cyc + 1;
   end

   // --------------------------------------------------
   // Check and register tasks
   // --------------------------------------------------

   task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("error at %0t: %s expected %0h actual %0h", $time, name, exp, act);
      end
   endtask

   task automatic reg_write(input int side, input aib_pkg::aib_reg_addr_t addr,
                            input aib_pkg::aib_reg_data_t data);
      aib_pkg::aib_avmm_req_t req;
      req           = '0;
      req.write     = 1'b1;
      req.address   = addr;
      req.writedata = data;
      if (addr == aib_pkg::AIB_REG_CTRL)
         ctrl_mirror[side] = data[1:0];
      @(posedge fwd_clk);
      if (side == 0)
         ms1_avmm_req <= req;
      else
         sl1_avmm_req <= req;
      // One-cycle strobe
      @(posedge fwd_clk);
      ms1_avmm_req <= '0;
      sl1_avmm_req <= '0;
   endtask

   task automatic reg_read(input int side, input aib_pkg::aib_reg_addr_t addr,
                           output aib_pkg::aib_reg_data_t data);
      aib_pkg::aib_avmm_req_t req;
      int                     n;
      logic                   got;
      req         = '0;
      req.read    = 1'b1;
      req.address = addr;
      n           = 0;
      got         = 1'b0;
      data        = '0;
      @(posedge fwd_clk);
      if (side == 0)
         ms1_avmm_req <= req;
      else
         sl1_avmm_req <= req;
      @(posedge fwd_clk);
      ms1_avmm_req <= '0;
      sl1_avmm_req <= '0;
      // Sample readdatavalid mid-cycle
      while (!got && (n < WAIT_LIMIT))
      begin
         @(negedge fwd_clk);
         n++;
         if ((side == 0) && (ms1_avmm_readdatavalid === 1'b1))
         begin
            data = ms1_avmm_readdata;
            got  = 1'b1;
         end
         else if ((side == 1) && (sl1_avmm_readdatavalid === 1'b1))
         begin
            data = sl1_avmm_readdata;
            got  = 1'b1;
         end
      end
      if (!got)
      begin
         errors++;
         $display("register read on side %0d got no readdatavalid", side);
      end
      else
         // Pulse due on the first falling edge after the strobe edge
         check(side ? "sl1_avmm_readdatavalid delay" : "ms1_avmm_readdatavalid delay",
               1, n);
   endtask

   task automatic check_reg(input int side, input aib_pkg::aib_reg_addr_t addr,
                            input aib_pkg::aib_reg_data_t exp, input string name);
      aib_pkg::aib_reg_data_t data;
      reg_read(side, addr, data);
      check(name, exp, data);
   endtask

   // Poll STATUS until lock matches
   task automatic wait_lock(input int side, input logic want);
      aib_pkg::aib_reg_data_t data;
      int                     n;
      n = 0;
      reg_read(side, aib_pkg::AIB_REG_STATUS, data);
      while ((data[0] !== want) && (n < 20))
      begin
         reg_read(side, aib_pkg::AIB_REG_STATUS, data);
         n++;
      end
      if (data[0] !== want)
      begin
         errors++;
         $display("lock on side %0d never became %0b", side, want);
      end
   endtask

   // --------------------------------------------------
   // Stimulus table and traffic
   // --------------------------------------------------

   task automatic fill_table();
      int          i;
      logic [95:0] rnd;
      for (i = 0; i < NUM_STIM; i++)
      begin
         // Sides alternate and every fourth row goes on phase 1
         stim[i].dir  = i[0];
         stim[i].ph   = ((i % 4) == 3);
         rnd          = {$random(seed), $random(seed), $random(seed)};
         stim[i].word = rnd[aib_pkg::AIB_WORD_W-1:0];
      end
      // Corner patterns up front
      stim[0].word = '1;
      stim[1].word = {38'h15_5555_5555, 38'h2a_aaaa_aaaa};
      stim[2].word = '0;
      stim[4].word = 76'h8000_0000_0000_0000_001;
   endtask

   task automatic send_word(input stim_t s);
      int   n;
      int   rx_side;
      logic next_ph;
      n       = 0;
      rx_side = s.dir ? 0 : 1;
      // Driven on the next edge and sampled one edge later
      @(negedge fwd_clk);
      next_ph = ~cyc[0];
      while ((next_ph != s.ph) && (n < 4))
      begin
         @(negedge fwd_clk);
         next_ph = ~cyc[0];
         n++;
      end
      if (next_ph != s.ph)
      begin
         errors++;
         $display("send on side %0d never found its phase", s.dir);
      end
      @(posedge fwd_clk);
      if (s.dir == 1'b0)
      begin
         ms1_tx_valid <= 1'b1;
         ms1_tx_data  <= s.word;
      end
      else
      begin
         sl1_tx_valid <= 1'b1;
         sl1_tx_data  <= s.word;
      end
      // Delivered only on phase 0 with both ends enabled
      if (!s.ph && ctrl_mirror[s.dir][0] && ctrl_mirror[rx_side][1])
      begin
         exp_rxcnt[rx_side]++;
         if (rx_side == 0)
         begin
            ms_exp_word.push_back(s.word);
            ms_exp_time.push_back($time + CLK_PERIOD);
         end
         else
         begin
            sl_exp_word.push_back(s.word);
            sl_exp_time.push_back($time + CLK_PERIOD);
         end
      end
      @(posedge fwd_clk);
      ms1_tx_valid <= 1'b0;
      sl1_tx_valid <= 1'b0;
   endtask

   task automatic run_table();
      int i;
      for (i = 0; i < NUM_STIM; i++)
         send_word(stim[i]);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (((ms_exp_word.size() + sl_exp_word.size()) > 0) && (n < WAIT_LIMIT))
      begin
         @(posedge fwd_clk);
         n++;
      end
      if ((ms_exp_word.size() + sl_exp_word.size()) > 0)
      begin
         errors++;
         $display("%0d expected words never arrived",
                  ms_exp_word.size() + sl_exp_word.size());
      end
      // Leave room for stray words to show up
      repeat (LATENCY + 2) @(posedge fwd_clk);
   endtask

   // --------------------------------------------------
   // Receive monitor
   // --------------------------------------------------

   task automatic take_word(input int side, input aib_pkg::aib_word_t word);
      aib_pkg::aib_word_t exp_word;
      time                exp_time;
      logic               got;
      got = 1'b0;
      if ((side == 0) && (ms_exp_word.size() > 0))
      begin
         exp_word = ms_exp_word.pop_front();
         exp_time = ms_exp_time.pop_front();
         got      = 1'b1;
      end
      else if ((side == 1) && (sl_exp_word.size() > 0))
      begin
         exp_word = sl_exp_word.pop_front();
         exp_time = sl_exp_time.pop_front();
         got      = 1'b1;
      end
      if (!got)
      begin
         errors++;
         $display("unexpected word %0h on side %0d at %0t", word, side, $time);
      end
      else
      begin
         check(side ? "sl1_rx_data" : "ms1_rx_data", exp_word, word);
         // Valid from edge n+4 to n+5 and seen at the falling edge between
         check(side ? "sl1_rx_valid time" : "ms1_rx_valid time",
               exp_time + LATENCY * CLK_PERIOD + CLK_PERIOD / 2, $time);
      end
   endtask

   always @(negedge fwd_clk)
   begin
      if (ms1_rx_valid === 1'b1)
         take_word(0, ms1_rx_data);
      if (sl1_rx_valid === 1'b1)
         take_word(1, sl1_rx_data);
   end

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------

   initial
   begin
      seed           = 63668;
      errors         = 0;
      checks         = 0;
      ctrl_mirror[0] = 2'b00;
      ctrl_mirror[1] = 2'b00;
      exp_rxcnt[0]   = 0;
      exp_rxcnt[1]   = 0;
      reset          = 1'b1;
      ms1_avmm_req   = '0;
      ms1_tx_valid   = 1'b0;
      ms1_tx_data    = '0;
      sl1_avmm_req   = '0;
      sl1_tx_valid   = 1'b0;
      sl1_tx_data    = '0;
      fill_table();
      repeat (3) @(posedge fwd_clk);
      reset <= 1'b0;

      // Reset values on both sides with no traffic
      for (int side = 0; side < 2; side++)
      begin
         check_reg(side, aib_pkg::AIB_REG_CTRL, 0, "CTRL");
         check_reg(side, aib_pkg::AIB_REG_STATUS, 0, "STATUS");
         check_reg(side, aib_pkg::AIB_REG_LOSS, 0, "LOSS");
         check_reg(side, aib_pkg::AIB_REG_RXCNT, 0, "RXCNT");
      end
      repeat (20) @(posedge fwd_clk);

      // Enable both ends and wait for lock
      reg_write(0, aib_pkg::AIB_REG_CTRL, 3);
      reg_write(1, aib_pkg::AIB_REG_CTRL, 3);
      wait_lock(0, 1'b1);
      wait_lock(1, 1'b1);

      // Table traffic where phase 1 rows must vanish
      run_table();
      wait_drain();
      check_reg(0, aib_pkg::AIB_REG_RXCNT, exp_rxcnt[0], "ms1 RXCNT");
      check_reg(1, aib_pkg::AIB_REG_RXCNT, exp_rxcnt[1], "sl1 RXCNT");

      // Master transmitter off breaks the slave's lock
      reg_write(0, aib_pkg::AIB_REG_CTRL, 2);
      wait_lock(1, 1'b0);
      check_reg(1, aib_pkg::AIB_REG_LOSS, 1, "sl1 LOSS");
      reg_write(1, aib_pkg::AIB_REG_LOSS, 32'h5);
      check_reg(1, aib_pkg::AIB_REG_LOSS, 0, "sl1 LOSS");
      check_reg(0, aib_pkg::AIB_REG_LOSS, 0, "ms1 LOSS");
      reg_write(0, aib_pkg::AIB_REG_CTRL, 3);
      wait_lock(1, 1'b1);
      run_table();
      wait_drain();
      check_reg(1, aib_pkg::AIB_REG_RXCNT, exp_rxcnt[1], "sl1 RXCNT");

      // Slave receive off keeps lock but delivers nothing
      reg_write(1, aib_pkg::AIB_REG_CTRL, 1);
      run_table();
      wait_drain();
      check_reg(1, aib_pkg::AIB_REG_STATUS, 1, "sl1 STATUS");
      check_reg(1, aib_pkg::AIB_REG_RXCNT, exp_rxcnt[1], "sl1 RXCNT");
      check_reg(0, aib_pkg::AIB_REG_RXCNT, exp_rxcnt[0], "ms1 RXCNT");

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== sim.f ====
common/aib_pkg.sv
aib/aib_tx_gearbox.sv
aib/aib_rx_aligner.sv
aib/aib_csr.sv
aib/aib_model_top.sv
hdl/aib_link_top.sv
sim/top_tb.sv
